// File: bench/ym_reg_cases.txt
// op arg value (hex): 1 address write, 2 data write, 3 check o_low, 4 check channel arg,
// 5 check lfrq pulse count; 0 ends the list
3 0 0   5 0 0
4 0 0  4 1 0  4 2 0  4 3 0  4 4 0  4 5 0  4 6 0  4 7 0
// data with no address, then addresses 08 and 40
2 0 FF  3 0 0
1 0 08  2 0 FF  1 0 40  2 0 FF  3 0 0
// global registers
1 0 01  2 0 A5  1 0 0F  2 0 93  1 0 10  2 0 C3
1 0 11  2 0 FE  1 0 12  2 0 7E  1 0 14  2 0 EA
1 0 18  2 0 5C  5 0 1
// 19 with bit 7 set, then clear without a new address
1 0 19  2 0 85  3 0 A5CF0E7EA9702800
2 0 33  3 0 A5CF0E7EA9702B30
1 0 1B  2 0 C2  3 0 A5CF0E7EA9702B3E
// new address redirects data, second lfrq write
1 0 01  2 0 11  1 0 18  2 0 3C  3 0 11CF0E7EA8F02B3E  5 0 2
// channel 3 block by block
1 0 23  2 0 DB  4 3 36C0000
1 0 2B  2 0 4E  4 3 36E7000
1 0 33  2 0 A4  4 3 36E7520
1 0 3B  2 0 52  4 3 36E7536
// channel 6 key code, others untouched
1 0 2E  2 0 7F  4 6 3F800  4 3 36E7536
4 0 0  4 1 0  4 2 0  4 4 0  4 5 0  4 7 0  5 0 2
0 0 0

// File: bench/ym_reg_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "ym_reg_macros.svh"

module ym_reg_sva (
    input  wire                      i_EMUCLK,
    input  wire                      mrst_n,
    input  wire ym_bus_pkg::wr_evt_t i_wr,
    input  wire                      i_cycle_31,
    input  wire                      i_lfrq_update,
    input  wire [`YM_SLOT_W-1:0]     i_slot
);

int fail_cnt = 0;

//////////////////////////////////////////////////////////////
// write event strobes

no_double_load: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
    !(i_wr.addr_ld && i_wr.data_ld))
    else begin
        fail_cnt++;
        $error("address and data load high in the same cycle");
    end

addr_ld_single: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
    i_wr.addr_ld |=> !i_wr.addr_ld)
    else begin
        fail_cnt++;
        $error("address load strobe longer than one cycle");
    end

data_ld_single: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
    i_wr.data_ld |=> !i_wr.data_ld)
    else begin
        fail_cnt++;
        $error("data load strobe longer than one cycle");
    end

//////////////////////////////////////////////////////////////
// lfo update and slot alignment

lfrq_pulse_single: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
    i_lfrq_update |=> !i_lfrq_update)
    else begin
        fail_cnt++;
        $error("lfrq update pulse longer than one cycle");
    end

slot_realign: assert property (@(posedge i_EMUCLK) disable iff (!mrst_n)
    i_cycle_31 |=> (i_slot == '0))
    else begin
        fail_cnt++;
        $error("slot counter not zero after cycle 31");
    end

endmodule

`default_nettype wire

// File: bench/ym_reg_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ym_reg_macros.svh"

module ym_reg_tb;

localparam int DEPTH  = 256;                    // three tokens per command
localparam int SETTLE = 2 * `YM_NUM_CH + 8;     // ring write latency plus margin

logic                   emuclk   = 1'b0;
logic                   mrst_n;
logic                   cs_n;
logic                   wr_n;
logic                   a0;
logic   [7:0]           d;
logic                   cycle_31 = 1'b0;
logic   [4:0]           frame    = 5'd0;        // free running timing frame
logic                   slot_aligned = 1'b0;    // slot follows frame after the first cycle_31

ym_param_pkg::lowreg_t  low;
logic                   lfrq_update;
logic [`YM_SLOT_W-1:0]  slot;
ym_param_pkg::ch_t      ch;

logic   [63:0]          cases [0:DEPTH-1];
int                     n_cmds    = 0;
int                     cycle_cnt = 0;
int                     pulse_cnt = 0;

ym_reg_top i_dut (
    .i_EMUCLK       (emuclk),
    .mrst_n         (mrst_n),
    .i_cs_n         (cs_n),
    .i_wr_n         (wr_n),
    .i_a0           (a0),
    .i_d            (d),
    .i_cycle_31     (cycle_31),
    .o_low          (low),
    .o_lfrq_update  (lfrq_update),
    .o_slot         (slot),
    .o_ch           (ch)
);

bind ym_reg_top ym_reg_sva u_sva (
    .i_EMUCLK       (i_EMUCLK),
    .mrst_n         (mrst_n),
    .i_wr           (wr_evt),
    .i_cycle_31     (i_cycle_31),
    .i_lfrq_update  (o_lfrq_update),
    .i_slot         (o_slot)
);

always #5 emuclk = ~emuclk;

task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
endtask

task automatic check_slot(input string name, input logic [`YM_SLOT_W-1:0] exp_slot);
    if (slot !== exp_slot) begin
        report_fail($sformatf("MISMATCH %s expected %0d actual %0d", name, exp_slot, slot));
    end
endtask

//////////////////////////////////////////////////////////////
// timing frame, pulse counter and run limit

always @(posedge emuclk) begin
    frame     <= frame + 5'd1;
    cycle_31  <= (frame == 5'd30);      // high while frame is 31
    cycle_cnt <= cycle_cnt + 1;
    if (mrst_n && cycle_31) begin
        slot_aligned <= 1'b1;
    end
    if (mrst_n && lfrq_update) begin
        pulse_cnt <= pulse_cnt + 1;
    end
    if (slot_aligned) begin
        check_slot("slot_count", frame);
    end
    if (i_dut.u_sva.fail_cnt != 0) begin
        report_fail("a bound assertion on the write events or pulses failed");
    end
    if (n_cmds > 0 && cycle_cnt == n_cmds * 60) begin
        $display("timeout after %0d cycles, the command list did not finish", cycle_cnt);
        $display("Simulation FAILED");
        $fatal(1, "run limit reached");
    end
end

// one host write cycle followed by a random idle gap
task automatic bus_write(input logic wr_a0, input logic [7:0] wr_byte);
    int gap;
    gap = `YM_WR_GAP + int'($urandom % (13 - `YM_WR_GAP));
    @(posedge emuclk);
    cs_n <= 1'b0;
    wr_n <= 1'b0;
    a0   <= wr_a0;
    d    <= wr_byte;
    @(posedge emuclk);
    cs_n <= 1'b1;
    wr_n <= 1'b1;
    repeat (gap - 1) @(posedge emuclk);
endtask

task automatic settle();
    repeat (SETTLE) @(posedge emuclk);
    @(negedge emuclk);                  // outputs are stable here
endtask

task automatic check_low(input string name, input ym_param_pkg::lowreg_t exp_low);
    if (low !== exp_low) begin
        report_fail($sformatf("MISMATCH %s expected %h actual %h", name, exp_low, low));
    end
endtask

task automatic check_ch(input string name, input int c, input ym_param_pkg::ch_t exp_ch);
    while (int'(slot) % `YM_NUM_CH != c) begin
        @(negedge emuclk);
    end
    if (ch !== exp_ch) begin
        report_fail($sformatf("MISMATCH %s ch%0d expected %h actual %h",
                              name, c, exp_ch, ch));
    end
endtask

task automatic check_pulse(input string name, input int exp_cnt);
    if (pulse_cnt != exp_cnt) begin
        report_fail($sformatf("MISMATCH %s lfrq pulses expected %0d actual %0d",
                              name, exp_cnt, pulse_cnt));
    end
endtask

//////////////////////////////////////////////////////////////
// command sequencer

initial begin
    int          idx;
    int          op;
    int          arg;
    logic [63:0] val;
    string       name;
    void'($urandom(32'hb7f0));
    mrst_n = 1'b0;
    cs_n   = 1'b1;
    wr_n   = 1'b1;
    a0     = 1'b0;
    d      = 8'h00;
    $readmemh("bench/ym_reg_cases.txt", cases);
    while (3 * n_cmds + 2 < DEPTH && cases[3 * n_cmds] >= 1 && cases[3 * n_cmds] <= 5) begin
        n_cmds++;
    end
    if (n_cmds == 0) begin
        report_fail("case file is empty or could not be read");
    end
    repeat (4) @(posedge emuclk);
    mrst_n <= 1'b1;
    for (idx = 0; idx < n_cmds; idx++) begin
        op   = int'(cases[3 * idx]);
        arg  = int'(cases[3 * idx + 1]);
        val  = cases[3 * idx + 2];
        name = $sformatf("case_%0d", idx);
        case (op)
            1: bus_write(1'b0, val[7:0]);   // address
            2: bus_write(1'b1, val[7:0]);   // data
            3: begin
                settle();
                check_low(name, ym_param_pkg::lowreg_t'(val));
            end
            4: begin
                settle();
                check_ch(name, arg, ym_param_pkg::ch_t'(val[25:0]));
            end
            default: begin
                settle();
                check_pulse(name, int'(val));
            end
        endcase
    end
    if (i_dut.u_sva.fail_cnt == 0) begin
        $display("Simulation PASSED");
        $finish;
    end
    else begin
        $display("%0d assertion failures seen", i_dut.u_sva.fail_cnt);
        $display("Simulation FAILED");
        $fatal(1, "assertion failures");
    end
end

endmodule

`default_nettype wire

// File: include/ym_reg_macros.svh
`ifndef YM_REG_MACROS_SVH
`define YM_REG_MACROS_SVH

//////////////////////////////////////////////////////////////
// low register addresses
`define YM_ADDR_TEST            8'h01
`define YM_ADDR_NOISE           8'h0F   // NE / NFRQ
`define YM_ADDR_CLKA1           8'h10   // timer A upper bits
`define YM_ADDR_CLKA2           8'h11   // timer A lower bits
`define YM_ADDR_CLKB            8'h12
`define YM_ADDR_TIMER           8'h14
`define YM_ADDR_LFRQ            8'h18
`define YM_ADDR_PMDAMD          8'h19
`define YM_ADDR_CTW             8'h1B

//////////////////////////////////////////////////////////////
// channel register blocks, eight addresses each
`define YM_CH_BASE_RLFLALG      8'h20
`define YM_CH_BASE_KC           8'h28
`define YM_CH_BASE_KF           8'h30
`define YM_CH_BASE_PMSAMS       8'h38

`define YM_NUM_CH               8       // channel ring length
`define YM_SLOT_W               5       // slot counter, 32 slots
`define YM_WR_GAP               6       // min cycles between host writes

`endif

// File: project.f
+incdir+include
source/ym_bus_pkg.sv
source/ym_param_pkg.sv
source/ym_bus_front.sv
source/ym_lowreg_bank.sv
source/ym_chreg_ring.sv
source/ym_reg_top.sv
bench/ym_reg_sva.sv
bench/ym_reg_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the register file testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module ym_reg_tb -Mdir obj_dir

./obj_dir/Vym_reg_tb | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    echo "run_sim: pass"
else
    echo "run_sim: fail"
    exit 1
fi

// File: source/ym_bus_front.sv
`timescale 1ns/1ps
`default_nettype none

module ym_bus_front (
    input  wire                 i_EMUCLK,
    input  wire                 mrst_n,

    input  wire                 i_cs_n,
    input  wire                 i_wr_n,
    input  wire                 i_a0,
    input  wire  [7:0]          i_d,

    output ym_bus_pkg::wr_evt_t o_wr
);

//////////////////////////////////////////////////////////////
// host write capture

logic           wr_stb;
logic   [7:0]   byte_q;         // held until the next write
logic   [1:0]   req;            // [0] address, [1] data
logic   [1:0]   req_set;

assign wr_stb  = ~i_cs_n & ~i_wr_n;
assign req_set = {i_a0, ~i_a0} & {2{wr_stb}};

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        byte_q <= 8'h00;
    end
    else if (wr_stb) begin
        byte_q <= i_d;
    end
end

//////////////////////////////////////////////////////////////
// two-stage synchronizer and load strobes

logic   [1:0]   sync0;
logic   [1:0]   sync1;
logic   [1:0]   ld_q;

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        req   <= 2'b00;
        sync0 <= 2'b00;
        sync1 <= 2'b00;
        ld_q  <= 2'b00;
    end
    else begin
        // request drops once the second stage has it
        req   <= req_set | (req & ~sync1);
        sync0 <= req;
        sync1 <= sync0;

        // req is still up only in the first cycle sync1 is high
        ld_q  <= sync1 & req;
    end
end

assign o_wr.addr_ld = ld_q[0];
assign o_wr.data_ld = ld_q[1];
assign o_wr.data    = byte_q;

endmodule

`default_nettype wire

// File: source/ym_bus_pkg.sv
`default_nettype none

// types seen on the host side of the register file
package ym_bus_pkg;

    // one write after it has crossed into the i_EMUCLK domain
    // addr_ld and data_ld are single-cycle strobes, never together
    typedef struct packed {
        logic       addr_ld;    // A0 low write
        logic       data_ld;    // A0 high write
        logic [7:0] data;       // byte captured at the strobe
    } wr_evt_t;

endpackage

`default_nettype wire

// File: source/ym_chreg_ring.sv
`timescale 1ns/1ps
`default_nettype none

`include "ym_reg_macros.svh"

module ym_chreg_ring (
    input  wire                      i_EMUCLK,
    input  wire                      mrst_n,

    input  wire ym_bus_pkg::wr_evt_t i_wr,
    input  wire                      i_cycle_31,

    output logic [`YM_SLOT_W-1:0]    o_slot,
    output ym_param_pkg::ch_t        o_ch
);

localparam int         NUM_CH       = `YM_NUM_CH;
localparam int         CH_W         = $clog2(NUM_CH);
localparam int         TAP          = NUM_CH - 2;      // see ring timing below
localparam logic [7:0] BASE_RLFLALG = `YM_CH_BASE_RLFLALG;
localparam logic [7:0] BASE_KC      = `YM_CH_BASE_KC;
localparam logic [7:0] BASE_KF      = `YM_CH_BASE_KF;
localparam logic [7:0] BASE_PMSAMS  = `YM_CH_BASE_PMSAMS;

//////////////////////////////////////////////////////////////
// high address / data hold

logic   [4:0]   hi_addr;        // offset inside 0x20..0x3F
logic           hi_addr_vld;
logic   [7:0]   hi_data;
logic           hi_data_vld;
logic           hi_range;

assign hi_range = i_wr.data[7:5] == BASE_RLFLALG[7:5];

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        hi_addr     <= 5'd0;
        hi_addr_vld <= 1'b0;
        hi_data     <= 8'h00;
        hi_data_vld <= 1'b0;
    end
    else begin
        if (i_wr.addr_ld) begin
            hi_addr_vld <= hi_range;    // low address drops it
            hi_data_vld <= 1'b0;
            if (hi_range) begin
                hi_addr <= i_wr.data[4:0];
            end
        end
        else if (i_wr.data_ld && hi_addr_vld) begin
            hi_data     <= i_wr.data;
            hi_data_vld <= 1'b1;
        end
    end
end

//////////////////////////////////////////////////////////////
// slot counter and registered slot match

logic   [`YM_SLOT_W-1:0]    slot_q;
logic                       ch_hit;
logic   en_rlflalg, en_kc, en_kf, en_pmsams;

assign ch_hit = hi_data_vld & (hi_addr[CH_W-1:0] == slot_q[CH_W-1:0]);

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        slot_q     <= '0;
        en_rlflalg <= 1'b0;
        en_kc      <= 1'b0;
        en_kf      <= 1'b0;
        en_pmsams  <= 1'b0;
    end
    else begin
        slot_q     <= i_cycle_31 ? '0 : slot_q + 1'b1;    // wraps at 32
        en_rlflalg <= ch_hit & (hi_addr[4:3] == BASE_RLFLALG[4:3]);
        en_kc      <= ch_hit & (hi_addr[4:3] == BASE_KC[4:3]);
        en_kf      <= ch_hit & (hi_addr[4:3] == BASE_KF[4:3]);
        en_pmsams  <= ch_hit & (hi_addr[4:3] == BASE_PMSAMS[4:3]);
    end
end

//////////////////////////////////////////////////////////////
// channel ring
// with slot n, the last stage holds channel n-1 (match was registered)
// so stage k holds channel n-2-k, and channel n sits at stage NUM_CH-2

ym_param_pkg::ch_t [NUM_CH-1:0] ring;
ym_param_pkg::ch_t              ring_in;

always_comb begin
    ring_in = ring[NUM_CH-1];           // recirculate
    if (en_rlflalg) begin
        ring_in.rl  = hi_data[7:6];
        ring_in.fl  = hi_data[5:3];
        ring_in.alg = hi_data[2:0];
    end
    if (en_kc) begin
        ring_in.kc = hi_data[6:0];
    end
    if (en_kf) begin
        ring_in.kf = hi_data[7:2];
    end
    if (en_pmsams) begin
        ring_in.pms = hi_data[6:4];
        ring_in.ams = hi_data[1:0];     // no AMS enable gating here
    end
end

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        ring <= '0;
    end
    else begin
        ring <= {ring[NUM_CH-2:0], ring_in};
    end
end

assign o_slot = slot_q;
assign o_ch   = ring[TAP];

endmodule

`default_nettype wire

// File: source/ym_lowreg_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "ym_reg_macros.svh"

module ym_lowreg_bank (
    input  wire                  i_EMUCLK,
    input  wire                  mrst_n,

    input  wire ym_bus_pkg::wr_evt_t i_wr,

    output ym_param_pkg::lowreg_t o_low,
    output logic                 o_lfrq_update
);

//////////////////////////////////////////////////////////////
// address latch

logic   [7:0]   addr_q;
logic           addr_vld;       // set by the first address write

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        addr_q   <= 8'h00;
        addr_vld <= 1'b0;
    end
    else if (i_wr.addr_ld) begin
        addr_q   <= i_wr.data;
        addr_vld <= 1'b1;
    end
end

logic                   wr_hit;     // data write to the latched address
ym_param_pkg::pmdamd_u  reg19;

assign wr_hit     = i_wr.data_ld & addr_vld;
assign reg19.raw  = i_wr.data;

// one pulse per data write to LFRQ
assign o_lfrq_update = wr_hit & (addr_q == `YM_ADDR_LFRQ);

//////////////////////////////////////////////////////////////
// static global registers

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        o_low <= '0;
    end
    else if (wr_hit) begin
        case (addr_q)
            `YM_ADDR_TEST: begin
                o_low.test <= i_wr.data;
            end
            `YM_ADDR_NOISE: begin
                o_low.ne   <= i_wr.data[7];
                o_low.nfrq <= i_wr.data[4:0];
            end
            `YM_ADDR_CLKA1: begin
                o_low.clka1 <= i_wr.data;
            end
            `YM_ADDR_CLKA2: begin
                o_low.clka2 <= i_wr.data[1:0];
            end
            `YM_ADDR_CLKB: begin
                o_low.clkb <= i_wr.data;
            end
            `YM_ADDR_TIMER: begin
                o_low.timerctrl <= i_wr.data[5:0];  // CSM bit not kept
            end
            `YM_ADDR_LFRQ: begin
                o_low.lfrq <= i_wr.data;
            end
            `YM_ADDR_PMDAMD: begin
                // bit 7 picks which of the two registers is loaded
                if (reg19.f.sel) begin
                    o_low.pmd <= reg19.f.depth;
                end
                else begin
                    o_low.amd <= reg19.f.depth;
                end
            end
            `YM_ADDR_CTW: begin
                o_low.ct <= i_wr.data[7:6];
                o_low.w  <= i_wr.data[1:0];
            end
            default: begin
                // nothing kept for other low addresses
            end
        endcase
    end
end

endmodule

`default_nettype wire

// File: source/ym_param_pkg.sv
`default_nettype none

// register contents as seen by the rest of the chip
package ym_param_pkg;

    // register 0x19 carries either PMD or AMD
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic       sel;    // 1 selects PMD, 0 selects AMD
            logic [6:0] depth;
        } f;
    } pmdamd_u;

    //////////////////////////////////////////////////////////////
    // global settings from the low address range
    typedef struct packed {
        logic [7:0] test;       // 0x01
        logic       ne;         // 0x0F[7]
        logic [4:0] nfrq;       // 0x0F[4:0]
        logic [7:0] clka1;      // 0x10
        logic [1:0] clka2;      // 0x11[1:0]
        logic [7:0] clkb;       // 0x12
        logic [5:0] timerctrl;  // 0x14[5:0]
        logic [7:0] lfrq;       // 0x18
        logic [6:0] pmd;        // 0x19, bit 7 set
        logic [6:0] amd;        // 0x19, bit 7 clear
        logic [1:0] ct;         // 0x1B[7:6]
        logic [1:0] w;          // 0x1B[1:0]
    } lowreg_t;

    //////////////////////////////////////////////////////////////
    // per channel parameters, 0x20..0x3F
    typedef struct packed {
        logic [1:0] rl;         // output enables
        logic [2:0] fl;         // feedback level
        logic [2:0] alg;        // algorithm
        logic [6:0] kc;         // key code
        logic [5:0] kf;         // key fraction
        logic [2:0] pms;        // phase mod sensitivity
        logic [1:0] ams;        // amplitude mod sensitivity
    } ch_t;

endpackage

`default_nettype wire

// File: source/ym_reg_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ym_reg_macros.svh"

module ym_reg_top (
    input  wire                         i_EMUCLK,
    input  wire                         mrst_n,

    // host bus
    input  wire                         i_cs_n,
    input  wire                         i_wr_n,
    input  wire                         i_a0,
    input  wire  [7:0]                  i_d,

    // timing generator
    input  wire                         i_cycle_31,

    output wire ym_param_pkg::lowreg_t  o_low,
    output wire                         o_lfrq_update,
    output wire  [`YM_SLOT_W-1:0]       o_slot,
    output wire ym_param_pkg::ch_t      o_ch
);

wire ym_bus_pkg::wr_evt_t  wr_evt;     // synchronized write, to both banks

ym_bus_front u_bus_front (
    .i_EMUCLK       (i_EMUCLK),
    .mrst_n         (mrst_n),
    .i_cs_n         (i_cs_n),
    .i_wr_n         (i_wr_n),
    .i_a0           (i_a0),
    .i_d            (i_d),
    .o_wr           (wr_evt)
);

ym_lowreg_bank u_lowreg_bank (
    .i_EMUCLK       (i_EMUCLK),
    .mrst_n         (mrst_n),
    .i_wr           (wr_evt),
    .o_low          (o_low),
    .o_lfrq_update  (o_lfrq_update)
);

ym_chreg_ring u_chreg_ring (
    .i_EMUCLK       (i_EMUCLK),
    .mrst_n         (mrst_n),
    .i_wr           (wr_evt),
    .i_cycle_31     (i_cycle_31),
    .o_slot         (o_slot),
    .o_ch           (o_ch)
);

endmodule

`default_nettype wire
